//--- hdl/rename_pkg.sv
// ==========================================================
// Shared geometry of the physical register free list
// 256 tags split into four banks of 64, one bank per lane
// The top two tag bits select the bank, the rest index it
// Tag 0 is reserved and never handed out
// ==========================================================
`default_nettype none

package rename_pkg;

	// ==========================================================
	// Register file geometry
	// ==========================================================

	// Total number of physical registers
	localparam int PREGS = 256;

	// One bank per rename lane
	localparam int NBANK = 4;

	// Tags owned by each bank
	localparam int BANK_REGS = 64;

	// ==========================================================
	// Tag and queue types
	// ==========================================================

	// Physical register tag, bits 7:6 name the owning bank
	typedef logic [7:0] pregno_t;

	// Index inside one bank
	// Also wide enough for queue pointers and the scan position
	typedef logic [5:0] bank_idx_t;

	// Queue occupancy needs one extra bit to hold a full bank
	typedef logic [6:0] bank_cnt_t;

endpackage

`default_nettype wire

//--- hdl/free_bank_if.sv
// ==========================================================
// One lane's link between the renamer and its free bank
// All strobes are already qualified by en, stall and the
// free map before they reach the bank
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

interface free_bank_if import rename_pkg::*; ();

	// Renamer to bank
	logic alloc;
	logic free_valid;
	pregno_t free_tag;
	// Pending bulk frees for this bank only, zero while en is low
	logic [BANK_REGS-1:0] bulk_slice;

	// Bank to renamer
	// Head of the queue, valid whenever empty is low
	pregno_t tag;
	// One-hot bulk tag returned this cycle
	logic [BANK_REGS-1:0] scan_pick;
	logic empty;

	modport renamer (
		output alloc, free_valid, free_tag, bulk_slice,
		input tag, scan_pick, empty
	);

	modport bank (
		input alloc, free_valid, free_tag, bulk_slice,
		output tag, scan_pick, empty
	);

endinterface

`default_nettype wire

//--- hdl/free_bank.sv
// ==========================================================
// Circular queue of free tags for a single bank
// Preset full in ascending order at reset, bank 0 skips tag 0
// A direct free wins the push port, the bulk scanner only
// runs in cycles without one
// The renamer must never pop an empty queue
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module free_bank import rename_pkg::*; #(
	parameter int bank_no = 0
) (
	input wire clk,
	input wire rst,
	free_bank_if.bank bus
);

	// ==========================================================
	// Queue storage and control
	// ==========================================================

	// Only the bank-local part of each tag is stored
	bank_idx_t queue [BANK_REGS];
	bank_idx_t rd_ptr;
	bank_idx_t wr_ptr;
	bank_cnt_t count;

	logic push;
	logic pop;
	bank_idx_t push_idx;

	// Bulk scanner state for the current cycle
	logic scan_hit;
	bank_idx_t scan_idx;

	// ==========================================================
	// Bulk free scanner
	// ==========================================================

	// Priority encoder for the lowest pending bit
	// Walking down from the top leaves the lowest set index behind
	always_comb begin
		scan_idx = '0;
		for (int i = BANK_REGS - 1; i >= 0; i--) begin
			if (bus.bulk_slice[i])
				scan_idx = bank_idx_t'(i);
		end
	end

	// The scanner shares the single push port with direct frees
	// so it backs off whenever a direct free is accepted
	assign scan_hit = (|bus.bulk_slice) & ~bus.free_valid;

	// Tell the renamer which pending bit was taken so it can
	// clear it and mark the tag free at the same edge
	assign bus.scan_pick = {{(BANK_REGS - 1){1'b0}}, scan_hit} << scan_idx;

	// ==========================================================
	// Push and pop
	// ==========================================================

	assign push = bus.free_valid | scan_hit;
	assign pop = bus.alloc;

	// Direct free tag already carries this bank's number on top
	assign push_idx = bus.free_valid ? bank_idx_t'(bus.free_tag) : scan_idx;

	// Head tag is rebuilt from the bank number and the stored index
	assign bus.tag = {2'(bank_no), queue[rd_ptr]};
	assign bus.empty = (count == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			// Fill with every tag of the bank in ascending order
			// Bank 0 starts at index 1 and so holds one tag fewer
			for (int i = 0; i < BANK_REGS; i++)
				queue[i] <= bank_idx_t'(i + (bank_no == 0));
			rd_ptr <= '0;
			// A full bank wraps the write pointer back to zero
			wr_ptr <= bank_idx_t'(BANK_REGS - (bank_no == 0));
			count <= bank_cnt_t'(BANK_REGS - (bank_no == 0));
		end else begin
			if (push) begin
				queue[wr_ptr] <= push_idx;
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop in one cycle leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// ==========================================================
	// Checks
	// ==========================================================

	// The free map qualification upstream keeps the queue from
	// ever taking a 65th tag
	assert property (@(posedge clk) disable iff (rst)
		(push && !pop) |-> (count < BANK_REGS))
		else $error("free_bank %0d overflow", bank_no);

	// Lanes must only return tags of their own bank
	assert property (@(posedge clk) disable iff (rst)
		bus.free_valid |-> (bus.free_tag[7:6] == 2'(bank_no)))
		else $error("free_bank %0d got foreign tag %0h", bank_no, bus.free_tag);

	// Stall masking in the renamer must stop pops on an empty bank
	assert property (@(posedge clk) disable iff (rst)
		bus.alloc |-> (count != '0))
		else $error("free_bank %0d popped while empty", bank_no);

endmodule

`default_nettype wire

//--- hdl/reg_renamer.sv
// ==========================================================
// Four-lane physical register free list
// Lane i allocates from and frees into bank i only
// Direct frees of tags that are already free are dropped
// Bulk frees drain one tag per bank per cycle, lowest first
// stall is combinational and blocks every lane's allocation
// Tag 0 is never allocated and never freed
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module reg_renamer import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire en,
	input wire [NBANK-1:0] alloc,
	input wire [NBANK-1:0] freevals,
	input wire pregno_t [NBANK-1:0] tags2free,
	input wire [PREGS-1:0] list2free,
	output pregno_t [NBANK-1:0] tags,
	output logic [PREGS-1:0] free_map,
	output logic stall
);

	// ==========================================================
	// Lane signals
	// ==========================================================

	free_bank_if bank_bus [NBANK] ();

	// Qualified strobes per lane
	logic [NBANK-1:0] alloc_go;
	logic [NBANK-1:0] free_go;
	logic [NBANK-1:0] bank_empty;

	// Bulk tags handed back by each bank this cycle
	logic [NBANK-1:0][BANK_REGS-1:0] scan_pick;

	// Tags waiting to be drained after a flush
	logic [PREGS-1:0] pending;
	logic [PREGS-1:0] pending_next;
	logic [PREGS-1:0] free_map_next;

	// Any empty bank holds off allocation on every lane
	assign stall = |bank_empty;

	// ==========================================================
	// Banks
	// ==========================================================

	for (genvar g = 0; g < NBANK; g++) begin : g_lane

		// Only allocate when every bank can supply a tag
		assign alloc_go[g] = en & alloc[g] & ~stall;

		// A tag that is already free must not enter the queue twice
		// Tag 0 is kept out of the free list entirely
		assign free_go[g] = en & freevals[g] & ~free_map[tags2free[g]] &
			(tags2free[g] != '0);

		assign bank_bus[g].alloc = alloc_go[g];
		assign bank_bus[g].free_valid = free_go[g];
		assign bank_bus[g].free_tag = tags2free[g];

		// Hiding the slice while en is low keeps the scanner quiet
		assign bank_bus[g].bulk_slice = en ? pending[g * BANK_REGS +: BANK_REGS] : '0;

		assign tags[g] = bank_bus[g].tag;
		assign scan_pick[g] = bank_bus[g].scan_pick;
		assign bank_empty[g] = bank_bus[g].empty;

		free_bank #(
			.bank_no(g)
		) u_bank (
			.clk(clk),
			.rst(rst),
			.bus(bank_bus[g])
		);

		// The queue head must agree with the free map
		assert property (@(posedge clk) disable iff (rst)
			alloc_go[g] |-> free_map[tags[g]])
			else $error("lane %0d allocated busy tag %0h", g, tags[g]);

	end

	// ==========================================================
	// Free map and pending bitmap
	// ==========================================================

	// The allocated head, the direct free and the scanned tag of
	// one lane are always distinct tags, so the order of the
	// updates below does not matter
	always_comb begin
		free_map_next = free_map;
		for (int i = 0; i < NBANK; i++) begin
			if (alloc_go[i])
				free_map_next[tags[i]] = 1'b0;
			if (free_go[i])
				free_map_next[tags2free[i]] = 1'b1;
			free_map_next[i * BANK_REGS +: BANK_REGS] =
				free_map_next[i * BANK_REGS +: BANK_REGS] | scan_pick[i];
		end
	end

	// Masking with the next free map drops scanned tags, tags freed
	// directly this cycle and flush bits for tags already free
	always_comb begin
		pending_next = (pending | list2free) & ~free_map_next;
		pending_next[0] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			free_map <= '1;
			free_map[0] <= 1'b0;
			pending <= '0;
		end else if (en) begin
			free_map <= free_map_next;
			pending <= pending_next;
		end
	end

endmodule

`default_nettype wire

//--- hdl/rename_top.sv
// ==========================================================
// Top level of the register free list with plain ports
// Lane i may only free tags whose top two bits equal i
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module rename_top import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire en,
	input wire [NBANK-1:0] alloc,
	input wire [NBANK-1:0] freevals,
	input wire pregno_t [NBANK-1:0] tags2free,
	input wire [PREGS-1:0] list2free,
	output pregno_t [NBANK-1:0] tags,
	output logic [PREGS-1:0] free_map,
	output logic stall
);

	// All state lives in the renamer and its banks
	reg_renamer u_renamer (
		.clk(clk),
		.rst(rst),
		.en(en),
		.alloc(alloc),
		.freevals(freevals),
		.tags2free(tags2free),
		.list2free(list2free),
		.tags(tags),
		.free_map(free_map),
		.stall(stall)
	);

endmodule

`default_nettype wire

//--- bench/rename_model.svh
// ==========================================================
// Reference model of the banked register free list
// Holds the expected queue of every bank, the free map and
// the pending flush bitmap, advanced once per clock edge
// Must be included inside a module that imports rename_pkg
// ==========================================================
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Expected queue contents of every bank, head first
pregno_t free_q [NBANK][$];

// Expected free map and flush bits still waiting to drain
logic [PREGS-1:0] exp_free_map;
logic [PREGS-1:0] exp_pending;

// Tags handed out at the most recent edge
logic [PREGS-1:0] last_alloc;

// Allocation is blocked while any bank has nothing to give
function automatic logic any_bank_empty();
	logic empty;
	empty = 1'b0;
	for (int b = 0; b < NBANK; b++) begin
		if (free_q[b].size() == 0)
			empty = 1'b1;
	end
	return empty;
endfunction

// Every bank starts full in ascending order, tag 0 left out
task automatic reset_model();
	for (int b = 0; b < NBANK; b++) begin
		free_q[b].delete();
		for (int i = 0; i < BANK_REGS; i++) begin
			if (b * BANK_REGS + i != 0)
				free_q[b].push_back(pregno_t'(b * BANK_REGS + i));
		end
	end
	exp_free_map = '1;
	exp_free_map[0] = 1'b0;
	exp_pending = '0;
	last_alloc = '0;
endtask

// The flush drains upward from the bottom of each bank
task automatic find_lowest_pending(input int b, output logic found, output pregno_t t);
	found = 1'b0;
	t = '0;
	for (int i = 0; i < BANK_REGS; i++) begin
		if (!found && exp_pending[b * BANK_REGS + i]) begin
			found = 1'b1;
			t = pregno_t'(b * BANK_REGS + i);
		end
	end
endtask

// One clock edge with the given inputs
task automatic advance_model(input logic en_v, input logic [NBANK-1:0] a,
	input logic [NBANK-1:0] f, input pregno_t [NBANK-1:0] t, input logic [PREGS-1:0] l);
	logic stall_now;
	logic take_free;
	logic found;
	logic [PREGS-1:0] next_map;
	pregno_t scan_tag;
	pregno_t head;
	last_alloc = '0;
	if (!en_v)
		return;
	stall_now = any_bank_empty();
	next_map = exp_free_map;
	for (int b = 0; b < NBANK; b++) begin
		// Only a tag that is currently busy may come back
		take_free = f[b] && !exp_free_map[t[b]] && (t[b] != '0);
		find_lowest_pending(b, found, scan_tag);
		if (a[b] && !stall_now) begin
			head = free_q[b].pop_front();
			next_map[head] = 1'b0;
			last_alloc[head] = 1'b1;
		end
		// A direct free takes the bank's only push slot
		if (take_free) begin
			free_q[b].push_back(t[b]);
			next_map[t[b]] = 1'b1;
		end else if (found) begin
			free_q[b].push_back(scan_tag);
			next_map[scan_tag] = 1'b1;
		end
	end
	exp_pending = (exp_pending | l) & ~next_map;
	exp_pending[0] = 1'b0;
	exp_free_map = next_map;
endtask

`endif

//--- bench/rename_tb.sv
// ==========================================================
// Testbench for the banked register free list
// Inputs change on the falling edge, outputs are compared
// on the falling edge against the included model
// Lanes with en high only free tags of their own bank
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

	logic clk;
	logic rst;
	logic en;
	logic [NBANK-1:0] alloc;
	logic [NBANK-1:0] freevals;
	pregno_t [NBANK-1:0] tags2free;
	logic [PREGS-1:0] list2free;
	pregno_t [NBANK-1:0] tags;
	logic [PREGS-1:0] free_map;
	logic stall;

	integer seed;
	int errors;

	`include "rename_model.svh"

	rename_top dut0 (
		.clk(clk),
		.rst(rst),
		.en(en),
		.alloc(alloc),
		.freevals(freevals),
		.tags2free(tags2free),
		.list2free(list2free),
		.tags(tags),
		.free_map(free_map),
		.stall(stall)
	);

	// 8 ns clock period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [PREGS-1:0] expected,
		input logic [PREGS-1:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// The outputs hang off state only, so they are steady here
	task automatic compare_outputs(input string name);
		check_val({name, " stall"}, PREGS'(any_bank_empty()), PREGS'(stall));
		check_val({name, " free_map"}, exp_free_map, free_map);
		check_val({name, " allocated tag still free"}, '0, free_map & last_alloc);
		// An empty bank shows a stale head, which means nothing
		for (int b = 0; b < NBANK; b++) begin
			if (free_q[b].size() != 0)
				check_val($sformatf("%s tags[%0d]", name, b),
					PREGS'(free_q[b][0]), PREGS'(tags[b]));
		end
	endtask

	task automatic run_cycle(input string name, input logic en_v, input logic [NBANK-1:0] a,
		input logic [NBANK-1:0] f, input pregno_t [NBANK-1:0] t, input logic [PREGS-1:0] l);
		@(negedge clk);
		compare_outputs(name);
		en = en_v;
		alloc = a;
		freevals = f;
		tags2free = t;
		list2free = l;
		advance_model(en_v, a, f, t, l);
	endtask

	// Search the bank from a random point for a tag in use
	function automatic pregno_t pick_busy_tag(input int b, input int start);
		pregno_t t;
		pregno_t found;
		found = pregno_t'(b * BANK_REGS + start);
		for (int k = 0; k < BANK_REGS; k++) begin
			t = pregno_t'(b * BANK_REGS + ((start + k) % BANK_REGS));
			if (t != '0 && !exp_free_map[t])
				found = t;
		end
		return found;
	endfunction

	// rate and bias count in quarters and bias steers toward busy tags
	task automatic random_frees(input int rate, input int bias,
		output logic [NBANK-1:0] f, output pregno_t [NBANK-1:0] t);
		int start;
		for (int b = 0; b < NBANK; b++) begin
			start = $random(seed) & 63;
			f[b] = ($random(seed) & 3) < rate;
			if (($random(seed) & 3) < bias)
				t[b] = pick_busy_tag(b, start);
			else
				t[b] = pregno_t'(b * BANK_REGS + start);
		end
	endtask

	function automatic logic [PREGS-1:0] random_mask();
		logic [PREGS-1:0] m;
		for (int w = 0; w < PREGS / 32; w++)
			m[w * 32 +: 32] = $random(seed);
		return m;
	endfunction

	initial begin
		logic [NBANK-1:0] f;
		pregno_t [NBANK-1:0] t;
		pregno_t [NBANK-1:0] snap_tags;
		logic [PREGS-1:0] snap_map;
		logic snap_stall;
		int waited;
		seed = 32'he978_43da;
		errors = 0;
		rst = 1'b1;
		en = 1'b0;
		alloc = '0;
		freevals = '0;
		tags2free = '0;
		list2free = '0;
		reset_model();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// ==========================================================
		// Reset state and random allocation
		// ==========================================================
		check_val("reset free_map", {{(PREGS - 1){1'b1}}, 1'b0}, free_map);
		check_val("reset stall", '0, PREGS'(stall));
		for (int b = 0; b < NBANK; b++)
			check_val($sformatf("reset tags[%0d]", b),
				PREGS'((b == 0) ? 1 : b * BANK_REGS), PREGS'(tags[b]));
		repeat (40)
			run_cycle("random alloc", 1'b1, NBANK'($random(seed)), '0, '0, '0);

		// Mixed traffic where some frees hit tags that are already free
		repeat (150) begin
			random_frees(2, 3, f, t);
			run_cycle("direct free", 1'b1, NBANK'($random(seed) & $random(seed)), f, t, '0);
		end

		// Tag 0 must be refused both as a direct free and as a flush bit
		run_cycle("tag 0 free", 1'b1, '0, NBANK'(1), '0, PREGS'(1));

		// ==========================================================
		// Flush mask drained against sparse direct frees
		// ==========================================================

		// Take a block of tags from every bank so the flush mask finds busy tags
		repeat (24)
			run_cycle("fill before flush", 1'b1, '1, '0, '0, '0);
		run_cycle("bulk load", 1'b1, '0, '0, '0, random_mask());
		waited = 0;
		while (exp_pending != '0 && waited < 200) begin
			random_frees(1, 3, f, t);
			run_cycle("bulk drain", 1'b1, '0, f, t, '0);
			waited++;
		end
		if (exp_pending != '0) begin
			errors++;
			$display("The bulk free mask did not drain within 200 cycles");
		end

		// ==========================================================
		// Stall on an empty bank and its release
		// ==========================================================
		waited = 0;
		while (!stall && waited < 300) begin
			run_cycle("alloc to empty", 1'b1, '1, '0, '0, '0);
			waited++;
		end
		if (!stall) begin
			errors++;
			$display("stall never rose while every lane kept allocating");
		end
		repeat (5)
			run_cycle("alloc under stall", 1'b1, '1, '0, '0, '0);
		// Hand one tag back to each empty bank
		for (int b = 0; b < NBANK; b++) begin
			f[b] = (free_q[b].size() == 0);
			t[b] = pick_busy_tag(b, $random(seed) & 63);
		end
		run_cycle("free empty bank", 1'b1, '0, f, t, '0);
		waited = 0;
		while (stall && waited < 20) begin
			run_cycle("stall release", 1'b1, '0, '0, '0, '0);
			waited++;
		end
		if (stall) begin
			errors++;
			$display("stall stayed high after every empty bank got a tag back");
		end

		// ==========================================================
		// Nothing may move with en low
		// ==========================================================
		run_cycle("en low", 1'b0, '0, '0, '0, '0);
		snap_tags = tags;
		snap_map = free_map;
		snap_stall = stall;
		repeat (30) begin
			for (int b = 0; b < NBANK; b++)
				t[b] = pregno_t'($random(seed));
			run_cycle("en low", 1'b0, NBANK'($random(seed)), NBANK'($random(seed)), t,
				random_mask());
			check_val("en low tags", PREGS'(snap_tags), PREGS'(tags));
			check_val("en low free_map", snap_map, free_map);
			check_val("en low stall", PREGS'(snap_stall), PREGS'(stall));
		end
		@(negedge clk);
		compare_outputs("final");

		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
hdl/rename_pkg.sv
hdl/free_bank_if.sv
hdl/free_bank.sv
hdl/reg_renamer.sv
hdl/rename_top.sv
bench/rename_tb.sv

//--- Makefile
# Verilator build and run of the register free list testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= rename_tb
SEED ?= 1
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass line"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP SEED OBJ_DIR FILELIST VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The status of the recipe is the status of the final grep
test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
